/* filelist.f */
+incdir+source
source/audioRegPkg.sv
source/audioStreamPkg.sv
source/audioTimingGen.sv
source/apbRegBridge.sv
source/audioChannel.sv
source/sampleFetcher.sv
source/audioMixer.sv
source/i2sTransmitter.sv
source/audioSystem.sv
verification/axilMemModel.sv
verification/audioSystemTb.sv

/* Makefile */
# Verilator build of the audio playback testbench

VERILATOR ?= verilator
TOP       ?= audioSystemTb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* verification/audioSystemTb.sv */
/* Directed tests against a reference mix model built from the voice rules.
   Words are decoded from the I2S lines. Voices are started mid-frame, when the fetcher is idle. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module audioSystemTb;

    import audioStreamPkg::*;

    localparam int FRAME_NS    = 64 * `AUDIO_BCLK_DIV * 4;
    localparam int TEST_FRAMES = 75; // Frames used by all tests rounded up
    localparam int MEM_WORDS   = 4096;

    logic        aclk     = 1'b0;
    logic        aresetn  = 1'b0;
    logic        psel     = 1'b0;
    logic        penable  = 1'b0;
    logic        pwrite   = 1'b0;
    logic [7:0]  paddr    = '0;
    logic [31:0] pwdata   = '0;
    logic [3:0]  memDelay = 4'd0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    logic [15:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        bclk;
    logic        lrclk;
    logic        dout;

    stereo_t                  words [$];
    shortint                  refMem [MEM_WORDS];
    int                       cfgStart [`AUDIO_VOICES];
    int                       cfgLen [`AUDIO_VOICES];
    bit                       cfgMono [`AUDIO_VOICES];
    bit                       cfgRight [`AUDIO_VOICES];
    bit                       cfgLoop [`AUDIO_VOICES];
    logic [`AUDIO_VOICES-1:0] activeMask = '0;
    logic [31:0]              rxShift = '0;
    logic                     prevLr = 1'b0;
    logic                     arHeld = 1'b0;
    logic [31:0]              heldAddr = '0;

    always #2 aclk = ~aclk;

    audioSystem i_audioSystem (
        .aclk(aclk), .aresetn(aresetn), .i_psel(psel), .i_penable(penable),
        .i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata),
        .o_pready(pready), .o_pslverr(pslverr), .o_araddr(araddr), .o_arprot(arprot),
        .o_arvalid(arvalid), .i_arready(arready), .i_rdata(rdata), .i_rresp(rresp),
        .i_rvalid(rvalid), .o_rready(rready), .o_bclk(bclk), .o_lrclk(lrclk), .o_dout(dout)
    );

    axilMemModel i_memModel (
        .aclk(aclk), .aresetn(aresetn), .i_maxDelay(memDelay), .i_araddr(araddr),
        .i_arvalid(arvalid), .o_arready(arready), .o_rdata(rdata), .o_rresp(rresp),
        .o_rvalid(rvalid), .i_rready(rready)
    );

    // Right LSB arrives as word select falls, completing the pair
    always @(posedge bclk) begin
        rxShift = {rxShift[30:0], dout};
        if (prevLr && !lrclk) begin
            words.push_back(stereo_t'(rxShift));
        end
        prevLr = lrclk;
    end

    initial begin
        #(TEST_FRAMES * FRAME_NS * 2);
        $display("Test failures found");
        $fatal(1, "watchdog expired before the tests finished");
    end

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // A read request stays up with a stable address until accepted
    always @(negedge aclk) begin
        if (aresetn) begin
            if (arHeld) begin
                checkEqual(arvalid, 1'b1, "arvalid before arready");
                checkEqual(araddr, heldAddr, "araddr before arready");
            end
            if (arvalid) begin
                checkEqual(arprot, 3'b000, "arprot of a data read");
            end
            arHeld   = arvalid && !arready;
            heldAddr = araddr;
        end
    end

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(posedge aclk);
        #1;
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge aclk);
        #1;
        penable = 1'b1;
        @(posedge aclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
        @(posedge aclk);
        #1;
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge aclk);
        #1;
        penable = 1'b1;
        #2;
        data = prdata; // Mid-cycle of the access phase
        err  = pslverr;
        @(posedge aclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic fillRamp(input int startAddr, input int len, input int first,
                            input int step);
        int idx;
        for (int i = 0; i < len; i++) begin
            idx = startAddr / 2 + i;
            refMem[idx] = shortint'(first + i * step);
            i_memModel.mem[idx] = {refMem[idx][7:0], refMem[idx][15:8]}; // Byte-swapped
        end
    endtask

    function automatic sample_t clipSample(input int sum);
        if (sum > 32767) begin
            return 16'sh7fff;
        end else if (sum < -32768) begin
            return 16'sh8000;
        end
        return 16'(sum);
    endfunction

    // Mix of the samples loaded f frames after the first load
    function automatic stereo_t expectedMix(input int frame);
        stereo_t mix;
        int      leftSum;
        int      rightSum;
        int      idx;
        shortint s;
        leftSum  = 0;
        rightSum = 0;
        for (int v = 0; v < `AUDIO_VOICES; v++) begin
            if (activeMask[v] && frame >= 0) begin
                if (cfgLoop[v]) begin
                    idx = frame % cfgLen[v];
                end else begin
                    idx = (frame < cfgLen[v]) ? frame : cfgLen[v] - 1; // Holds the last one
                end
                s = refMem[cfgStart[v] / 2 + idx];
                if (cfgMono[v]) begin
                    leftSum  += s;
                    rightSum += s;
                end else if (cfgRight[v]) begin
                    rightSum += s;
                end else begin
                    leftSum += s;
                end
            end
        end
        mix.left  = clipSample(leftSum);
        mix.right = clipSample(rightSum);
        return mix;
    endfunction

    task automatic setupVoice(input int v, input int startAddr, input int len,
                              input bit mono, input bit right, input bit loop);
        cfgStart[v]   = startAddr;
        cfgLen[v]     = len;
        cfgMono[v]    = mono;
        cfgRight[v]   = right;
        cfgLoop[v]    = loop;
        activeMask[v] = 1'b1;
        apbWrite(8'(v * 16 + 4), startAddr);
        apbWrite(8'(v * 16 + 8), len);
    endtask

    task automatic stopVoices();
        for (int v = 0; v < `AUDIO_VOICES; v++) begin
            apbWrite(8'(v * 16), 32'd0);
        end
        activeMask = '0;
    endtask

    task automatic playAndCheck(input int frames);
        stereo_t want;
        @(posedge lrclk);
        for (int v = 0; v < `AUDIO_VOICES; v++) begin
            if (activeMask[v]) begin
                apbWrite(8'(v * 16), {28'd0, cfgLoop[v], cfgRight[v], cfgMono[v], 1'b1});
            end
        end
        words.delete();
        while (words.size() < frames + 2) begin
            @(posedge aclk);
        end
        // words[0] is the frame of the CTRL write and words[1] precedes the first load
        for (int k = 1; k < frames + 2; k++) begin
            want = expectedMix(k - 2);
            checkEqual(words[k].left, want.left, $sformatf("left of frame %0d", k - 2));
            checkEqual(words[k].right, want.right, $sformatf("right of frame %0d", k - 2));
        end
    endtask

    task automatic idleAfterReset();
        logic [31:0] data;
        logic        err;
        checkEqual(pready, 1'b1, "pready");
        apbRead(8'h80, data, err);
        checkEqual(data, 32'd0, "playing bits after reset");
        checkEqual(err, 1'b0, "slave error on status read");
        apbRead(8'h0c, data, err);
        checkEqual(err, 1'b1, "slave error on register select 3");
        while (words.size() < 3) begin
            @(posedge aclk);
        end
        for (int k = 0; k < 3; k++) begin
            checkEqual(words[k], 32'd0, "decoded word after reset");
        end
    endtask

    task automatic monoRampPlayback();
        fillRamp(32'h200, 16, -6000, 1237);
        setupVoice(0, 32'h200, 16, 1'b1, 1'b0, 1'b0);
        playAndCheck(12);
        stopVoices();
    endtask

    task automatic sidePanning();
        fillRamp(32'h400, 4, 100, 100);
        fillRamp(32'h500, 4, 1000, 1000);
        fillRamp(32'h600, 4, -7, -7);
        setupVoice(0, 32'h400, 4, 1'b0, 1'b1, 1'b1); // Right only
        setupVoice(1, 32'h500, 4, 1'b0, 1'b0, 1'b1);
        setupVoice(2, 32'h600, 4, 1'b1, 1'b0, 1'b1);
        playAndCheck(8);
        stopVoices();
    endtask

    task automatic mixSaturation();
        for (int v = 0; v < 4; v++) begin
            fillRamp(32'h700 + v * 8, 2, 30000, 0);
            setupVoice(v, 32'h700 + v * 8, 2, 1'b1, 1'b0, 1'b1);
        end
        playAndCheck(4);
        checkEqual($unsigned(words[5].left), 32'h7fff, "positive clip");
        stopVoices();
        for (int v = 0; v < 4; v++) begin
            fillRamp(32'h700 + v * 8, 2, -30000, 0);
            setupVoice(v, 32'h700 + v * 8, 2, 1'b1, 1'b0, 1'b1);
        end
        playAndCheck(4);
        checkEqual($unsigned(words[5].right), 32'h8000, "negative clip");
        stopVoices();
    endtask

    task automatic endOfSampleAndLoop();
        logic [31:0] data;
        logic        err;
        fillRamp(32'h800, 4, 500, 500);
        fillRamp(32'h900, 3, -300, -300);
        setupVoice(0, 32'h800, 4, 1'b0, 1'b0, 1'b0);
        setupVoice(1, 32'h900, 3, 1'b0, 1'b1, 1'b1);
        playAndCheck(9);
        apbRead(8'h80, data, err);
        checkEqual(data, 32'h2, "playing bits after voice 0 ran out");
        stopVoices();
    endtask

    task automatic randomBackPressure();
        @(posedge aclk);
        #1;
        memDelay = 4'd7;
        setupVoice(0, 32'h200, 16, 1'b1, 1'b0, 1'b0);
        playAndCheck(12);
        stopVoices();
        memDelay = 4'd0;
    endtask

    initial begin
        void'($urandom(32'hea2d));
        repeat (5) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        idleAfterReset();
        monoRampPlayback();
        sidePanning();
        mixSaturation();
        endOfSampleAndLoop();
        randomBackPressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/axilMemModel.sv */
/* AXI-Lite read slave over a 4096-word sample memory. Addresses wrap at 8 KB.
   Ready and valid delays are random up to i_maxDelay cycles. Responses are always OKAY. */
`timescale 1ns/1ps
`default_nettype none

module axilMemModel (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [3:0]  i_maxDelay,
    input  logic [31:0] i_araddr,
    input  logic        i_arvalid,
    output logic        o_arready,
    output logic [15:0] o_rdata,
    output logic [1:0]  o_rresp,
    output logic        o_rvalid,
    input  logic        i_rready
);

    logic [15:0] mem [4096];
    logic [11:0] wordIdx;
    logic [3:0]  stall;
    logic        pending; // Address taken and data not yet offered

    function automatic logic [3:0] pickDelay(input logic [3:0] maxDelay);
        return 4'($urandom % (32'(maxDelay) + 32'd1));
    endfunction

    initial begin
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 16'(a * 40503); // Odd multiplier spreads every address bit
        end
    end

    assign o_rresp = 2'b00;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rdata   <= '0;
            wordIdx   <= '0;
            stall     <= '0;
            pending   <= 1'b0;
        end else begin
            o_arready <= 1'b0;
            if (o_rvalid) begin
                if (i_rready) begin
                    o_rvalid <= 1'b0;
                    stall    <= pickDelay(i_maxDelay); // Wait before the next arready
                end
            end else if (pending) begin
                if (stall != '0) begin
                    stall <= stall - 4'd1;
                end else begin
                    o_rvalid <= 1'b1;
                    o_rdata  <= mem[wordIdx];
                    pending  <= 1'b0;
                end
            end else if (o_arready && i_arvalid) begin
                wordIdx <= i_araddr[12:1];
                pending <= 1'b1;
                stall   <= pickDelay(i_maxDelay);
            end else if (i_arvalid) begin
                if (stall != '0) begin
                    stall <= stall - 4'd1;
                end else begin
                    o_arready <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/audioSystem.sv */
/* Eight-voice playback: APB configuration, AXI-Lite sample reads, I2S output.
   aclk drives everything; bit clock and word select are divided from it. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module audioSystem (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic [31:0] o_araddr,
    output logic [2:0]  o_arprot,
    output logic        o_arvalid,
    input  logic        i_arready,
    input  logic [15:0] i_rdata,
    input  logic [1:0]  i_rresp,
    input  logic        i_rvalid,
    output logic        o_rready,
    output logic        o_bclk,
    output logic        o_lrclk,
    output logic        o_dout
);

    import audioRegPkg::*;
    import audioStreamPkg::*;

    chanWrite_t               chanWrite;
    logic [`AUDIO_VOICES-1:0] playing;
    logic [`AUDIO_VOICES-1:0] mono;
    logic [`AUDIO_VOICES-1:0] right;
    logic [`AUDIO_VOICES-1:0] load;
    logic [31:0]              nextAddr [`AUDIO_VOICES];
    sample_t                  chanSamples [`AUDIO_VOICES];
    sample_t                  fetchedSample;
    stereo_t                  mix;
    axilAr_t                  ar;
    axilR_t                   r;
    logic                     bitTick;
    logic                     frameStart;

    assign o_araddr  = ar.araddr;
    assign o_arprot  = ar.arprot;
    assign o_arvalid = ar.arvalid;
    assign r         = '{rdata: i_rdata, rresp: i_rresp, rvalid: i_rvalid};

    audioTimingGen i_timingGen (
        .aclk(aclk), .aresetn(aresetn), .o_bclk(o_bclk), .o_lrclk(o_lrclk),
        .o_bitTick(bitTick), .o_frameStart(frameStart)
    );

    apbRegBridge i_regBridge (
        .aclk(aclk), .aresetn(aresetn), .i_psel(i_psel), .i_penable(i_penable),
        .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
        .o_pready(o_pready), .o_pslverr(o_pslverr), .i_playing(playing),
        .o_chanWrite(chanWrite)
    );

    for (genvar v = 0; v < `AUDIO_VOICES; v++) begin : gVoice
        audioChannel #(.VOICE_INDEX(v)) i_channel (
            .aclk(aclk), .aresetn(aresetn), .i_chanWrite(chanWrite), .i_load(load[v]),
            .i_sample(fetchedSample), .o_playing(playing[v]), .o_mono(mono[v]),
            .o_right(right[v]), .o_nextAddr(nextAddr[v]), .o_sample(chanSamples[v])
        );
    end

    sampleFetcher i_fetcher (
        .aclk(aclk), .aresetn(aresetn), .i_frameStart(frameStart), .i_playing(playing),
        .i_nextAddr(nextAddr), .o_ar(ar), .i_arready(i_arready), .i_r(r),
        .o_rready(o_rready), .o_load(load), .o_sample(fetchedSample)
    );

    audioMixer i_mixer (
        .aclk(aclk), .aresetn(aresetn), .i_samples(chanSamples), .i_mono(mono),
        .i_right(right), .o_mix(mix)
    );

    i2sTransmitter i_transmitter (
        .aclk(aclk), .aresetn(aresetn), .i_bitTick(bitTick), .i_frameStart(frameStart),
        .i_mix(mix), .o_dout(o_dout)
    );

endmodule

`default_nettype wire

/* source/i2sTransmitter.sv */
/* Standard I2S framing with 16-bit words in a 32-bit frame.
   The MSB follows one bit clock after the word select edge. */
`timescale 1ns/1ps
`default_nettype none

module i2sTransmitter (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    i_bitTick,
    input  logic                    i_frameStart,
    input  audioStreamPkg::stereo_t i_mix,
    output logic                    o_dout
);

    logic [31:0] shiftReg;

    // Frame start always lands on a bit tick
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            shiftReg <= '0;
            o_dout   <= 1'b0;
        end else if (i_bitTick) begin
            o_dout <= shiftReg[31]; // LSB of the last right word on frame start
            if (i_frameStart) begin
                shiftReg <= {i_mix.left, i_mix.right};
            end else begin
                shiftReg <= {shiftReg[30:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* source/audioMixer.sv */
/* Sums all voices with no volume control and clips each side to 16 bits.
   Output is registered one cycle behind the inputs. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module audioMixer (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  audioStreamPkg::sample_t  i_samples [`AUDIO_VOICES],
    input  logic [`AUDIO_VOICES-1:0] i_mono,
    input  logic [`AUDIO_VOICES-1:0] i_right,
    output audioStreamPkg::stereo_t  o_mix
);

    import audioStreamPkg::*;

    localparam int SB       = `AUDIO_SAMPLE_BITS;
    localparam int SUM_BITS = SB + $clog2(`AUDIO_VOICES);

    logic signed [SUM_BITS-1:0] leftSum;
    logic signed [SUM_BITS-1:0] rightSum;

    function automatic sample_t saturate(input logic signed [SUM_BITS-1:0] sum);
        // In range when all bits above the sample's sign bit agree
        if (&sum[SUM_BITS-1:SB-1] || ~|sum[SUM_BITS-1:SB-1]) begin
            return sample_t'(sum[SB-1:0]);
        end else if (sum[SUM_BITS-1]) begin
            return {1'b1, {(SB - 1){1'b0}}};
        end
        return {1'b0, {(SB - 1){1'b1}}};
    endfunction

    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int v = 0; v < `AUDIO_VOICES; v++) begin
            if (i_mono[v] || !i_right[v]) begin
                leftSum = leftSum + {{(SUM_BITS - SB){i_samples[v][SB-1]}}, i_samples[v]};
            end
            if (i_mono[v] || i_right[v]) begin
                rightSum = rightSum + {{(SUM_BITS - SB){i_samples[v][SB-1]}}, i_samples[v]};
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_mix <= '0;
        end else begin
            o_mix.left  <= saturate(leftSum);
            o_mix.right <= saturate(rightSum);
        end
    end

endmodule

`default_nettype wire

/* source/sampleFetcher.sv */
/* Reads one sample per playing voice each frame, voice 0 first.
   An error response loads a zero sample. Frame starts during a pass are ignored. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module sampleFetcher (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     i_frameStart,
    input  logic [`AUDIO_VOICES-1:0] i_playing,
    input  logic [31:0]              i_nextAddr [`AUDIO_VOICES],
    output audioStreamPkg::axilAr_t  o_ar,
    input  logic                     i_arready,
    input  audioStreamPkg::axilR_t   i_r,
    output logic                     o_rready,
    output logic [`AUDIO_VOICES-1:0] o_load,
    output audioStreamPkg::sample_t  o_sample
);

    import audioStreamPkg::*;

    localparam int IDX_BITS = $clog2(`AUDIO_VOICES);
    localparam logic [IDX_BITS:0] DONE = (IDX_BITS + 1)'(`AUDIO_VOICES);

    typedef enum logic [1:0] {
        ST_ADDR,
        ST_DATA,
        ST_PASS
    } fetchState_t;

    fetchState_t         state;
    logic [IDX_BITS:0]   voicePtr; // DONE when idle
    logic [IDX_BITS-1:0] voiceIdx;
    logic [31:0]         araddr;
    logic                arvalid;
    logic                idle;
    logic                rDone;

    assign voiceIdx = voicePtr[IDX_BITS-1:0];
    assign idle     = (voicePtr == DONE);
    assign rDone    = i_r.rvalid && o_rready;
    assign o_ar     = '{araddr: araddr, arprot: 3'b000, arvalid: arvalid};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= ST_ADDR;
            voicePtr <= DONE;
            arvalid  <= 1'b0;
            o_rready <= 1'b0;
            o_load   <= '0;
        end else begin
            o_load <= '0;
            case (state)
                ST_ADDR: begin
                    if (idle) begin
                        if (i_frameStart) begin
                            voicePtr <= '0;
                        end
                    end else if (arvalid) begin
                        if (i_arready) begin
                            arvalid  <= 1'b0;
                            o_rready <= 1'b1;
                            state    <= ST_DATA;
                        end
                    end else if (i_playing[voiceIdx]) begin
                        arvalid <= 1'b1;
                    end else begin
                        voicePtr <= voicePtr + 1'b1; // Skip silent voice
                    end
                end
                ST_DATA: begin
                    if (rDone) begin
                        o_rready         <= 1'b0;
                        o_load[voiceIdx] <= 1'b1;
                        state            <= ST_PASS;
                    end
                end
                ST_PASS: begin
                    voicePtr <= voicePtr + 1'b1;
                    state    <= ST_ADDR;
                end
                default: state <= ST_ADDR;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == ST_ADDR && !idle && !arvalid) begin
            araddr <= i_nextAddr[voiceIdx];
        end
        if (state == ST_DATA && rDone) begin
            // Memory holds samples byte-swapped
            o_sample <= i_r.rresp[1] ? sample_t'('0) : {i_r.rdata[7:0], i_r.rdata[15:8]};
        end
    end

endmodule

`default_nettype wire

/* source/audioChannel.sv */
/* One voice. A CTRL write with enable but a zero length does not start playback.
   A CTRL write in the same cycle as a load wins over the load. */
`timescale 1ns/1ps
`default_nettype none

module audioChannel #(
    parameter int VOICE_INDEX = 0
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  audioRegPkg::chanWrite_t  i_chanWrite,
    input  logic                     i_load,
    input  audioStreamPkg::sample_t  i_sample,
    output logic                     o_playing,
    output logic                     o_mono,
    output logic                     o_right,
    output logic [31:0]              o_nextAddr,
    output audioStreamPkg::sample_t  o_sample
);

    import audioRegPkg::*;

    logic [31:0] startAddr;
    logic [31:0] length;
    logic [31:0] remaining;
    logic        loop;
    logic        hit;

    assign hit = i_chanWrite.valid && (i_chanWrite.voice == VOICE_BITS'(VOICE_INDEX));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            startAddr  <= '0;
            length     <= '0;
            remaining  <= '0;
            loop       <= 1'b0;
            o_playing  <= 1'b0;
            o_mono     <= 1'b0;
            o_right    <= 1'b0;
            o_nextAddr <= '0;
            o_sample   <= '0;
        end else begin
            if (i_load && o_playing) begin
                o_sample <= i_sample;
                if (remaining == 32'd1) begin
                    if (loop) begin
                        o_nextAddr <= startAddr;
                        remaining  <= length;
                    end else begin
                        o_playing <= 1'b0; // Last sample stays held
                    end
                end else begin
                    o_nextAddr <= o_nextAddr + 32'd2;
                    remaining  <= remaining - 32'd1;
                end
            end
            if (hit) begin
                case (i_chanWrite.sel)
                    REG_START:  startAddr <= i_chanWrite.data.raw;
                    REG_LENGTH: length <= i_chanWrite.data.raw;
                    REG_CTRL: begin
                        o_mono  <= i_chanWrite.data.ctrl.mono;
                        o_right <= i_chanWrite.data.ctrl.right;
                        loop    <= i_chanWrite.data.ctrl.loop;
                        if (i_chanWrite.data.ctrl.enable) begin
                            o_playing  <= (length != '0);
                            o_nextAddr <= startAddr;
                            remaining  <= length;
                        end else begin
                            o_playing <= 1'b0;
                            o_sample  <= '0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/apbRegBridge.sv */
/* APB slave with no wait states. Voice registers are write-only and read as 0.
   Address 0x80 returns the playing bits; register select 3 answers with PSLVERR. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module apbRegBridge (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     i_psel,
    input  logic                     i_penable,
    input  logic                     i_pwrite,
    input  logic [7:0]               i_paddr,
    input  logic [31:0]              i_pwdata,
    output logic [31:0]              o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    input  logic [`AUDIO_VOICES-1:0] i_playing,
    output audioRegPkg::chanWrite_t  o_chanWrite
);

    import audioRegPkg::*;

    logic access;
    logic chanSpace;
    logic reserved;

    assign access    = i_psel && i_penable;
    assign chanSpace = !i_paddr[7];
    assign reserved  = chanSpace && (i_paddr[3:2] == 2'd3);

    assign o_pready  = 1'b1;
    assign o_pslverr = access && reserved;

    always_comb begin
        o_prdata = '0;
        if (i_paddr == 8'h80) begin
            o_prdata = {{(32 - `AUDIO_VOICES){1'b0}}, i_playing};
        end
    end

    // One-cycle command per completed write
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_chanWrite <= '0;
        end else begin
            o_chanWrite.valid <= access && i_pwrite && chanSpace && !reserved;
            if (access && i_pwrite) begin
                o_chanWrite.voice    <= i_paddr[4 +: VOICE_BITS];
                o_chanWrite.sel      <= chanRegSel_t'(i_paddr[3:2]);
                o_chanWrite.data.raw <= i_pwdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/audioTimingGen.sv */
/* Bit clock and word select are plain levels derived from aclk, not clocks.
   Word select and the strobes change together on the falling bit clock. */
`timescale 1ns/1ps
`default_nettype none

`include "audioSettings.svh"

module audioTimingGen (
    input  logic aclk,
    input  logic aresetn,
    output logic o_bclk,
    output logic o_lrclk,
    output logic o_bitTick,
    output logic o_frameStart
);

    localparam int DIV_BITS = (`AUDIO_BCLK_DIV > 1) ? $clog2(`AUDIO_BCLK_DIV) : 1;

    logic [DIV_BITS-1:0] divCnt;
    logic [4:0]          bitCnt;
    logic                halfDone;

    assign halfDone = (divCnt == DIV_BITS'(`AUDIO_BCLK_DIV - 1));
    assign o_lrclk  = bitCnt[4]; // Low during the left word

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            divCnt       <= '0;
            bitCnt       <= '0;
            o_bclk       <= 1'b0;
            o_bitTick    <= 1'b0;
            o_frameStart <= 1'b0;
        end else begin
            o_bitTick    <= 1'b0;
            o_frameStart <= 1'b0;
            if (halfDone) begin
                divCnt <= '0;
                o_bclk <= ~o_bclk;
                if (o_bclk) begin // Falling bit clock
                    bitCnt       <= bitCnt + 5'd1;
                    o_bitTick    <= 1'b1;
                    o_frameStart <= (bitCnt == 5'd31);
                end
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/audioStreamPkg.sv */
/* Sample-path and memory read types.
   Only the AXI-Lite read channels exist. */
`default_nettype none

`include "audioSettings.svh"

package audioStreamPkg;

    typedef logic signed [`AUDIO_SAMPLE_BITS-1:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic [2:0]  arprot;
        logic        arvalid;
    } axilAr_t;

    // One sample per 16-bit beat
    typedef struct packed {
        logic [15:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axilR_t;

endpackage

`default_nettype wire

/* source/audioRegPkg.sv */
/* Register-side types shared by the APB bridge and the voices.
   Register select 3 is reserved and has no enum value. */
`default_nettype none

`include "audioSettings.svh"

package audioRegPkg;

    localparam int VOICE_BITS = $clog2(`AUDIO_VOICES);

    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_START  = 2'd1,
        REG_LENGTH = 2'd2
    } chanRegSel_t;

    // Low nibble of the CTRL word
    typedef struct packed {
        logic [27:0] reserved;
        logic        loop;
        logic        right;
        logic        mono;
        logic        enable;
    } chanCtrl_t;

    typedef union packed {
        chanCtrl_t   ctrl;
        logic [31:0] raw; // Start address or length
    } chanRegWord_t;

    typedef struct packed {
        logic                  valid;
        logic [VOICE_BITS-1:0] voice;
        chanRegSel_t           sel;
        chanRegWord_t          data;
    } chanWrite_t;

endpackage

`default_nettype wire

/* source/audioSettings.svh */
/* Build-time constants of the audio subsystem.
   A frame lasts 64 * AUDIO_BCLK_DIV aclk cycles and the fetcher needs all
   playing voices read within it. The register map assumes at most 8 voices. */
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Voices mixed into the output
`define AUDIO_VOICES 8

// aclk cycles per half bit-clock period
`define AUDIO_BCLK_DIV 4

`define AUDIO_SAMPLE_BITS 16

`endif
